// ==== Bender.yml ====
package:
  name: prf_top

sources:
  - files:
      - common/prf_geometry_pkg.sv
      - common/prf_request_pkg.sv
      - logic/masked_priority_picker.sv
      - read_path/prf_read_arbiter.sv
      - write_path/prf_wb_arbiter.sv
      - logic/prf_bank_array.sv
      - logic/prf_top.sv

  - target: test
    files:
      - verification/prf_tb.sv

// ==== common/prf_geometry_pkg.sv ====
// register file geometry: bank layout, register widths and data types
package prf_geometry_pkg;

    // --------------------
    // sizes

    // physical registers in the whole file
    localparam int PR_COUNT = 64;
    localparam int BANK_COUNT = 4;

    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);
    localparam int LOG_BANK_COUNT = $clog2(BANK_COUNT);

    // low PR bits pick the bank, the rest pick the row
    localparam int UPPER_PR_WIDTH = LOG_PR_COUNT - LOG_BANK_COUNT;
    localparam int ROWS_PER_BANK = PR_COUNT / BANK_COUNT;

    localparam int DATA_WIDTH = 32;

    // read ports on each bank
    localparam int READ_PORTS = 2;

    // --------------------
    // types

    // full physical register number
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    // row inside one bank
    typedef logic [UPPER_PR_WIDTH-1:0] upper_pr_t;

    typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

// ==== common/prf_request_pkg.sv ====
// requester definitions: reader and writer counts and their bit-vector types
package prf_request_pkg;

    // --------------------
    // counts

    // read requesters
    localparam int RR_COUNT = 4;

    // write requesters
    localparam int WR_COUNT = 4;

    // --------------------
    // types

    // one bit per reader
    typedef logic [RR_COUNT-1:0] rr_vec_t;

    // one bit per writer
    typedef logic [WR_COUNT-1:0] wr_vec_t;

endpackage

// ==== logic/masked_priority_picker.sv ====
// masked priority picker: one-hot grant of the highest request, masked requests first
`timescale 1ns/1ps

module masked_priority_picker #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req,
    input  logic [WIDTH-1:0] mask,
    output logic [WIDTH-1:0] grant
);

    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] pick_src;

    assign masked_req = req & mask;

    // fall back to every request when nothing masked is pending
    assign pick_src = (|masked_req) ? masked_req : req;

    // --------------------
    // highest set bit

    // scan upward, later hits replace earlier ones
    always_comb begin
        grant = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (pick_src[i]) begin
                grant = '0;
                grant[i] = 1'b1;
            end
        end
    end

    // grant must come from req and name at most one requester
    always_comb begin
        assert final ($onehot0(grant) && ((grant & ~req) == '0))
        else $error("picker grant is not one-hot within req");
    end

endmodule

// ==== logic/prf_bank_array.sv ====
// banked register storage: one write and two combinational reads per bank
`timescale 1ns/1ps

module prf_bank_array
    import prf_geometry_pkg::*;
(
    input  logic                                      CLK,
    input  logic                                      nRST,

    // write side, straight from the bus stage
    input  logic [BANK_COUNT-1:0]                     wb_bus_valid,
    input  upper_pr_t [BANK_COUNT-1:0]                wb_bus_row,
    input  data_t [BANK_COUNT-1:0]                    wb_bus_data,

    // read side
    input  upper_pr_t [BANK_COUNT-1:0][READ_PORTS-1:0] rd_row,
    output data_t [BANK_COUNT-1:0][READ_PORTS-1:0]     rd_data
);

    // --------------------
    // storage

    // distributed array, cleared on reset
    data_t [BANK_COUNT-1:0][ROWS_PER_BANK-1:0] mem;

    // at most one row per bank per cycle
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mem <= '0;
        end else begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (wb_bus_valid[b]) begin
                    mem[b][wb_bus_row[b]] <= wb_bus_data[b];
                end
            end
        end
    end

    // --------------------
    // reads

    // rows are already registered upstream
    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int p = 0; p < READ_PORTS; p++) begin
                rd_data[b][p] = mem[b][rd_row[b][p]];
            end
        end
    end

endmodule

// ==== logic/prf_top.sv ====
// physical register file top: read arbiter, writeback arbiter and banked array
`timescale 1ns/1ps

module prf_top
    import prf_geometry_pkg::*;
    import prf_request_pkg::*;
(
    input  logic                                      CLK,
    input  logic                                      nRST,

    // readers
    input  rr_vec_t                                   rd_req_valid,
    input  pr_t [RR_COUNT-1:0]                        rd_req_pr,
    output rr_vec_t                                   rd_ack,
    output rr_vec_t                                   rd_port,
    output data_t [BANK_COUNT-1:0][READ_PORTS-1:0]    rd_data,

    // writers
    input  wr_vec_t                                   wb_valid,
    input  data_t [WR_COUNT-1:0]                      wb_data,
    input  pr_t [WR_COUNT-1:0]                        wb_pr,
    output wr_vec_t                                   wb_ready,

    // writeback bus and forwarding
    output logic [BANK_COUNT-1:0]                     wb_bus_valid,
    output upper_pr_t [BANK_COUNT-1:0]                wb_bus_row,
    output data_t [BANK_COUNT-1:0]                    wb_bus_data,
    output data_t [BANK_COUNT-1:0]                    forward_data
);

    // registered read rows into the array
    upper_pr_t [BANK_COUNT-1:0][READ_PORTS-1:0] rd_row;

    prf_read_arbiter u_read_arb (
        .CLK         (CLK),
        .nRST        (nRST),
        .rd_req_valid(rd_req_valid),
        .rd_req_pr   (rd_req_pr),
        .rd_ack      (rd_ack),
        .rd_port     (rd_port),
        .rd_row      (rd_row)
    );

    prf_wb_arbiter u_wb_arb (
        .CLK         (CLK),
        .nRST        (nRST),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .wb_pr       (wb_pr),
        .wb_ready    (wb_ready),
        .wb_bus_valid(wb_bus_valid),
        .wb_bus_row  (wb_bus_row),
        .wb_bus_data (wb_bus_data),
        .forward_data(forward_data)
    );

    // the bus stage writes the array in the cycle it is shown
    prf_bank_array u_array (
        .CLK         (CLK),
        .nRST        (nRST),
        .wb_bus_valid(wb_bus_valid),
        .wb_bus_row  (wb_bus_row),
        .wb_bus_data (wb_bus_data),
        .rd_row      (rd_row),
        .rd_data     (rd_data)
    );

endmodule

// ==== prf_top.f ====
common/prf_geometry_pkg.sv
common/prf_request_pkg.sv
logic/masked_priority_picker.sv
read_path/prf_read_arbiter.sv
write_path/prf_wb_arbiter.sv
logic/prf_bank_array.sv
logic/prf_top.sv
verification/prf_tb.sv

// ==== read_path/prf_read_arbiter.sv ====
// read arbiter: holds unacknowledged reads and grants two ports per bank each cycle
`timescale 1ns/1ps

module prf_read_arbiter
    import prf_geometry_pkg::*;
    import prf_request_pkg::*;
(
    input  logic                                      CLK,
    input  logic                                      nRST,

    // requests by reader
    input  rr_vec_t                                   rd_req_valid,
    input  pr_t [RR_COUNT-1:0]                        rd_req_pr,

    // same-cycle answer by reader
    output rr_vec_t                                   rd_ack,
    output rr_vec_t                                   rd_port,

    // registered rows by bank and port
    output upper_pr_t [BANK_COUNT-1:0][READ_PORTS-1:0] rd_row
);

    // --------------------
    // signals

    // requests that lost last cycle
    rr_vec_t            held_valid;
    pr_t [RR_COUNT-1:0] held_pr;

    // priority mask from last cycle's acks
    rr_vec_t last_mask;
    rr_vec_t next_mask;

    // held request first, new request otherwise
    rr_vec_t            merged_valid;
    pr_t [RR_COUNT-1:0] merged_pr;

    rr_vec_t [BANK_COUNT-1:0] req_by_bank;
    rr_vec_t [BANK_COUNT-1:0] port0_grant;
    rr_vec_t [BANK_COUNT-1:0] port1_req;
    rr_vec_t [BANK_COUNT-1:0] port1_grant;

    upper_pr_t [BANK_COUNT-1:0][READ_PORTS-1:0] next_row;

    // --------------------
    // merge and route

    always_comb begin
        for (int rr = 0; rr < RR_COUNT; rr++) begin
            merged_valid[rr] = held_valid[rr] | rd_req_valid[rr];
            merged_pr[rr] = held_valid[rr] ? held_pr[rr] : rd_req_pr[rr];
        end

        // bank from the low PR bits
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int rr = 0; rr < RR_COUNT; rr++) begin
                req_by_bank[b][rr] = merged_valid[rr]
                    && (merged_pr[rr][LOG_BANK_COUNT-1:0] == LOG_BANK_COUNT'(b));
            end
        end
    end

    // --------------------
    // two ports per bank

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        // port 1 sees everything except port 0's winner
        assign port1_req[b] = req_by_bank[b] & ~port0_grant[b];

        masked_priority_picker #(
            .WIDTH(RR_COUNT)
        ) u_port0_pick (
            .req  (req_by_bank[b]),
            .mask (last_mask),
            .grant(port0_grant[b])
        );

        masked_priority_picker #(
            .WIDTH(RR_COUNT)
        ) u_port1_pick (
            .req  (port1_req[b]),
            .mask (last_mask),
            .grant(port1_grant[b])
        );
    end

    // ack, port, next mask and row select
    always_comb begin
        rd_ack = '0;
        rd_port = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            rd_ack |= port0_grant[b] | port1_grant[b];
            rd_port |= port1_grant[b];
        end

        // every reader below the highest ack goes first next cycle
        next_mask = '0;
        for (int rr = RR_COUNT - 2; rr >= 0; rr--) begin
            next_mask[rr] = rd_ack[rr+1] | next_mask[rr+1];
        end

        // one-hot mux of the upper PR bits
        next_row = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int rr = 0; rr < RR_COUNT; rr++) begin
                next_row[b][0] |= merged_pr[rr][LOG_PR_COUNT-1:LOG_BANK_COUNT]
                    & {UPPER_PR_WIDTH{port0_grant[b][rr]}};
                next_row[b][1] |= merged_pr[rr][LOG_PR_COUNT-1:LOG_BANK_COUNT]
                    & {UPPER_PR_WIDTH{port1_grant[b][rr]}};
            end
        end
    end

    // --------------------
    // state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            held_pr <= '0;
            last_mask <= '0;
            rd_row <= '0;
        end else begin
            held_valid <= merged_valid & ~rd_ack;
            held_pr <= merged_pr;
            last_mask <= next_mask;
            rd_row <= next_row;
        end
    end

    // a reader waits for its ack before asking again
    for (genvar rr = 0; rr < RR_COUNT; rr++) begin : g_req_check
        held_blocks_new_req: assert property (
            @(posedge CLK) disable iff (!nRST)
            held_valid[rr] |-> !rd_req_valid[rr]
        ) else $error("reader %0d requested while its read was held", rr);
    end

endmodule

// ==== verification/prf_tb.sv ====
// register file testbench: directed and random traffic checked against a reference model
`timescale 1ns/1ps

module prf_tb
    import prf_geometry_pkg::*;
    import prf_request_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PEND_SLOTS = 16;
    localparam int MAX_WB_AGE = 4;
    localparam int MAX_RD_WAIT = 3;

    logic CLK;
    logic nRST;
    integer seed;
    int cycle_count = 0;

    rr_vec_t                                rd_req_valid;
    pr_t [RR_COUNT-1:0]                     rd_req_pr;
    rr_vec_t                                rd_ack;
    rr_vec_t                                rd_port;
    data_t [BANK_COUNT-1:0][READ_PORTS-1:0] rd_data;
    wr_vec_t                                wb_valid;
    data_t [WR_COUNT-1:0]                   wb_data;
    pr_t [WR_COUNT-1:0]                     wb_pr;
    wr_vec_t                                wb_ready;
    logic [BANK_COUNT-1:0]                  wb_bus_valid;
    upper_pr_t [BANK_COUNT-1:0]             wb_bus_row;
    data_t [BANK_COUNT-1:0]                 wb_bus_data;
    data_t [BANK_COUNT-1:0]                 forward_data;

    // writer stimulus queues
    pr_t   wq_pr [WR_COUNT][$];
    data_t wq_data [WR_COUNT][$];

    // --------------------
    // reference model state

    // accepted writes not yet seen on the bus
    logic [PEND_SLOTS-1:0] pend_valid;
    pr_t   pend_pr [PEND_SLOTS];
    data_t pend_data [PEND_SLOTS];
    int    pend_writer [PEND_SLOTS];
    int    pend_age [PEND_SLOTS];
    int    pend_count;

    data_t shadow [PR_COUNT];

    // reads held inside the arbiter
    rr_vec_t out_valid;
    pr_t     out_pr [RR_COUNT];
    int      out_wait [RR_COUNT];

    // data due on each bank and port next cycle
    logic [READ_PORTS-1:0] exp_valid [BANK_COUNT];
    data_t                 exp_data [BANK_COUNT][READ_PORTS];

    logic wr_burst_done;
    logic rd_burst_done;

    logic [PEND_SLOTS-1:0] on_bus;
    logic [BANK_COUNT-1:0] bus_expected;
    wr_vec_t               waiting;
    logic                  wr_same_bank;
    logic                  rd_same_bank;

    prf_top UUT (
        .CLK         (CLK),
        .nRST        (nRST),
        .rd_req_valid(rd_req_valid),
        .rd_req_pr   (rd_req_pr),
        .rd_ack      (rd_ack),
        .rd_port     (rd_port),
        .rd_data     (rd_data),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .wb_pr       (wb_pr),
        .wb_ready    (wb_ready),
        .wb_bus_valid(wb_bus_valid),
        .wb_bus_row  (wb_bus_row),
        .wb_bus_data (wb_bus_data),
        .forward_data(forward_data)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    // low PR bits pick the bank
    function automatic logic [LOG_BANK_COUNT-1:0] bank_of(input pr_t pr);
        return pr[LOG_BANK_COUNT-1:0];
    endfunction

    function automatic upper_pr_t row_of(input pr_t pr);
        return pr[LOG_PR_COUNT-1:LOG_BANK_COUNT];
    endfunction

    task automatic stop_with_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // --------------------
    // combinational model

    always_comb begin
        bus_expected = '0;
        waiting = '0;
        for (int e = 0; e < PEND_SLOTS; e++) begin
            on_bus[e] = pend_valid[e] && wb_bus_valid[bank_of(pend_pr[e])]
                && (wb_bus_row[bank_of(pend_pr[e])] == row_of(pend_pr[e]))
                && (wb_bus_data[bank_of(pend_pr[e])] == pend_data[e]);
            if (on_bus[e]) begin
                bus_expected[bank_of(pend_pr[e])] = 1'b1;
            end
            // still sitting in the writer's buffer
            if (pend_valid[e] && !on_bus[e]) begin
                waiting[pend_writer[e]] = 1'b1;
            end
        end
        wr_same_bank = 1'b1;
        rd_same_bank = 1'b1;
        for (int i = 1; i < WR_COUNT; i++) begin
            if (bank_of(wb_pr[i]) != bank_of(wb_pr[0])) begin
                wr_same_bank = 1'b0;
            end
        end
        for (int i = 1; i < RR_COUNT; i++) begin
            if (bank_of(rd_req_pr[i]) != bank_of(rd_req_pr[0])) begin
                rd_same_bank = 1'b0;
            end
        end
    end

    // --------------------
    // model update at mid-cycle

    always @(negedge CLK or negedge nRST) begin : ref_model
        logic [PEND_SLOTS-1:0] shown;
        logic [BANK_COUNT-1:0] bank_taken;
        logic [LOG_BANK_COUNT-1:0] bank;
        pr_t cur_pr;
        logic cur_valid;
        int slot;
        if (!nRST) begin
            pend_valid = '0;
            pend_count = 0;
            out_valid = '0;
            wr_burst_done = 1'b0;
            rd_burst_done = 1'b0;
            for (int e = 0; e < PEND_SLOTS; e++) begin
                pend_age[e] = 0;
            end
            for (int i = 0; i < PR_COUNT; i++) begin
                shadow[i] = '0;
            end
            for (int b = 0; b < BANK_COUNT; b++) begin
                exp_valid[b] = '0;
            end
            for (int r = 0; r < RR_COUNT; r++) begin
                out_wait[r] = 0;
            end
        end else begin
            // retire what the bus shows, one write per bank
            shown = on_bus;
            bank_taken = '0;
            for (int e = 0; e < PEND_SLOTS; e++) begin
                bank = bank_of(pend_pr[e]);
                if (shown[e] && !bank_taken[bank]) begin
                    bank_taken[bank] = 1'b1;
                    pend_valid[e] = 1'b0;
                    pend_count--;
                end
            end
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (wb_bus_valid[b]) begin
                    shadow[{wb_bus_row[b], LOG_BANK_COUNT'(b)}] = wb_bus_data[b];
                end
            end
            for (int e = 0; e < PEND_SLOTS; e++) begin
                if (pend_valid[e]) begin
                    pend_age[e]++;
                end
            end
            // new accepted writes
            for (int w = 0; w < WR_COUNT; w++) begin
                slot = -1;
                for (int e = 0; e < PEND_SLOTS; e++) begin
                    if (!pend_valid[e] && slot < 0) begin
                        slot = e;
                    end
                end
                if (wb_valid[w] && wb_ready[w] && slot >= 0) begin
                    pend_valid[slot] = 1'b1;
                    pend_pr[slot] = wb_pr[w];
                    pend_data[slot] = wb_data[w];
                    pend_writer[slot] = w;
                    pend_age[slot] = 0;
                    pend_count++;
                end
            end
            if (wb_valid == '1 && wr_same_bank) begin
                wr_burst_done = 1'b1;
            end

            // read data comes from the array as written through this cycle
            for (int b = 0; b < BANK_COUNT; b++) begin
                exp_valid[b] = '0;
            end
            for (int r = 0; r < RR_COUNT; r++) begin
                cur_valid = rd_req_valid[r] || out_valid[r];
                cur_pr = out_valid[r] ? out_pr[r] : rd_req_pr[r];
                if (rd_ack[r]) begin
                    bank = bank_of(cur_pr);
                    exp_valid[bank][rd_port[r]] = 1'b1;
                    exp_data[bank][rd_port[r]] = shadow[cur_pr];
                    out_valid[r] = 1'b0;
                    out_wait[r] = 0;
                end else if (cur_valid) begin
                    out_valid[r] = 1'b1;
                    out_pr[r] = cur_pr;
                    out_wait[r]++;
                end
            end
            if (rd_req_valid == '1 && rd_same_bank) begin
                rd_burst_done = 1'b1;
            end
        end
    end

    // --------------------
    // checks

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank_check
        bus_matches_write: assert property (
            @(negedge CLK) disable iff (!nRST)
            wb_bus_valid[b] |-> bus_expected[b]
        ) else stop_with_error($sformatf("bank %0d bus shows a write never accepted", b));

        forward_follows_bus: assert property (
            @(negedge CLK) disable iff (!nRST)
            wb_bus_valid[b] |=> (forward_data[b] == $past(wb_bus_data[b]))
        ) else stop_with_error($sformatf("bank %0d forward data differs from bus", b));

        for (genvar p = 0; p < READ_PORTS; p++) begin : g_port
            read_data_matches: assert property (
                @(negedge CLK) disable iff (!nRST)
                exp_valid[b][p] |-> (rd_data[b][p] == exp_data[b][p])
            ) else stop_with_error($sformatf("bank %0d port %0d read data %h, expected %h",
                b, p, rd_data[b][p], exp_data[b][p]));
        end
    end

    for (genvar w = 0; w < WR_COUNT; w++) begin : g_writer_check
        ready_tracks_buffer: assert property (
            @(negedge CLK) disable iff (!nRST)
            wb_ready[w] == !(wb_valid[w] && waiting[w])
        ) else stop_with_error($sformatf("writer %0d ready is %b", w, wb_ready[w]));
    end

    // age is one less than the cycles since acceptance
    for (genvar e = 0; e < PEND_SLOTS; e++) begin : g_latency_check
        write_latency: assert property (
            @(negedge CLK) disable iff (!nRST)
            pend_valid[e] |-> (pend_age[e] < MAX_WB_AGE)
        ) else stop_with_error($sformatf("write to PR %0d not on the bus in time",
            pend_pr[e]));
    end

    for (genvar r = 0; r < RR_COUNT; r++) begin : g_reader_check
        ack_has_request: assert property (
            @(negedge CLK) disable iff (!nRST)
            rd_ack[r] |-> (rd_req_valid[r] || out_valid[r])
        ) else stop_with_error($sformatf("reader %0d acked with no request", r));

        read_wait_bounded: assert property (
            @(negedge CLK) disable iff (!nRST)
            out_wait[r] <= MAX_RD_WAIT
        ) else stop_with_error($sformatf("reader %0d held for %0d cycles", r, out_wait[r]));
    end

    pend_capacity: assert property (
        @(negedge CLK) disable iff (!nRST)
        pend_count < PEND_SLOTS
    ) else stop_with_error("more writes in flight than the model can track");

    // with an empty mask the highest writer goes first
    first_write_burst: assert property (
        @(negedge CLK) disable iff (!nRST)
        (wb_valid == '1 && wr_same_bank && !wr_burst_done)
            |=> (wb_bus_valid[bank_of($past(wb_pr[3]))]
                && wb_bus_data[bank_of($past(wb_pr[3]))] == $past(wb_data[3]))
    ) else stop_with_error("first same-bank burst did not put writer 3 on the bus");

    first_read_burst: assert property (
        @(negedge CLK) disable iff (!nRST)
        (rd_req_valid == '1 && rd_same_bank && !rd_burst_done)
            |-> (rd_ack == 4'b1100 && rd_port == 4'b0100)
                ##1 (rd_ack == 4'b0011 && rd_port == 4'b0001)
    ) else stop_with_error($sformatf("same-bank reads got ack %b port %b", rd_ack, rd_port));

    // --------------------
    // stimulus

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    // offer queued items, hold each until accepted
    task automatic run_writes();
        wr_vec_t accepted;
        logic busy;
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (int w = 0; w < WR_COUNT; w++) begin
                wb_valid[w] = (wq_pr[w].size() > 0);
                if (wb_valid[w]) begin
                    wb_pr[w] = wq_pr[w][0];
                    wb_data[w] = wq_data[w][0];
                    busy = 1'b1;
                end
            end
            if (busy) begin
                @(negedge CLK);
                accepted = wb_valid & wb_ready;
                next_cycle();
                for (int w = 0; w < WR_COUNT; w++) begin
                    if (accepted[w]) begin
                        void'(wq_pr[w].pop_front());
                        void'(wq_data[w].pop_front());
                    end
                end
            end
        end
    endtask

    task automatic wait_writes_settled();
        while (pend_count != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    // one request per reader, then wait for every ack
    task automatic read_round(input rr_vec_t valid, input pr_t [RR_COUNT-1:0] prs);
        rr_vec_t outstanding;
        // idle cycle first so the mask starts empty
        next_cycle();
        rd_req_valid = valid;
        rd_req_pr = prs;
        outstanding = valid;
        while (outstanding != '0) begin
            @(negedge CLK);
            outstanding = outstanding & ~rd_ack;
            next_cycle();
            rd_req_valid = '0;
        end
    endtask

    function automatic pr_t [RR_COUNT-1:0] random_read_prs();
        pr_t [RR_COUNT-1:0] prs;
        for (int r = 0; r < RR_COUNT; r++) begin
            prs[r] = pr_t'($random(seed));
        end
        return prs;
    endfunction

    initial begin
        pr_t [RR_COUNT-1:0] burst_prs;
        seed = 32'h283d_08a9;
        nRST = 1'b0;
        rd_req_valid = '0;
        rd_req_pr = '0;
        wb_valid = '0;
        wb_data = '0;
        wb_pr = '0;
        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;

        // a freshly reset file reads zero
        repeat (3) begin
            read_round(rr_vec_t'($random(seed)), random_read_prs());
        end

        // two items per writer, all in bank 2
        for (int w = 0; w < WR_COUNT; w++) begin
            for (int k = 0; k < 2; k++) begin
                wq_pr[w].push_back({upper_pr_t'(w * 2 + k), LOG_BANK_COUNT'(2)});
                wq_data[w].push_back(data_t'($random(seed)));
            end
        end
        run_writes();
        wait_writes_settled();

        // random write rounds
        repeat (40) begin
            for (int w = 0; w < WR_COUNT; w++) begin
                if (($random(seed) & 3) != 0) begin
                    wq_pr[w].push_back(pr_t'($random(seed)));
                    wq_data[w].push_back(data_t'($random(seed)));
                end
            end
            run_writes();
            wait_writes_settled();
        end

        // all readers on bank 1
        for (int r = 0; r < RR_COUNT; r++) begin
            burst_prs[r] = {upper_pr_t'($random(seed)), LOG_BANK_COUNT'(1)};
        end
        read_round('1, burst_prs);

        repeat (40) begin
            read_round(rr_vec_t'($random(seed)), random_read_prs());
        end
        repeat (3) next_cycle();

        $display("Regression passed");
        $finish;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1);
        end
    end

endmodule

// ==== write_path/prf_wb_arbiter.sv ====
// writeback arbiter: per-writer holding buffer, one write per bank, bus stage and forwarding
`timescale 1ns/1ps

module prf_wb_arbiter
    import prf_geometry_pkg::*;
    import prf_request_pkg::*;
(
    input  logic                       CLK,
    input  logic                       nRST,

    // writebacks by writer
    input  wr_vec_t                    wb_valid,
    input  data_t [WR_COUNT-1:0]       wb_data,
    input  pr_t [WR_COUNT-1:0]         wb_pr,
    output wr_vec_t                    wb_ready,

    // writeback bus by bank
    output logic [BANK_COUNT-1:0]      wb_bus_valid,
    output upper_pr_t [BANK_COUNT-1:0] wb_bus_row,
    output data_t [BANK_COUNT-1:0]     wb_bus_data,

    // bus data one cycle later
    output data_t [BANK_COUNT-1:0]     forward_data
);

    // --------------------
    // signals

    // one-entry buffer per writer
    wr_vec_t              buf_valid;
    data_t [WR_COUNT-1:0] buf_data;
    pr_t [WR_COUNT-1:0]   buf_pr;

    // what each writer offers this cycle
    wr_vec_t              cand_valid;
    data_t [WR_COUNT-1:0] cand_data;
    pr_t [WR_COUNT-1:0]   cand_pr;

    wr_vec_t [BANK_COUNT-1:0] req_by_bank;
    wr_vec_t [BANK_COUNT-1:0] grant_by_bank;
    wr_vec_t                  wb_ack;

    wr_vec_t last_mask;
    wr_vec_t next_mask;

    logic [BANK_COUNT-1:0]      next_bus_valid;
    upper_pr_t [BANK_COUNT-1:0] next_bus_row;
    data_t [BANK_COUNT-1:0]     next_bus_data;

    // --------------------
    // ready

    // from valid and buffer state only, so it settles early in the cycle
    assign wb_ready = ~(wb_valid & buf_valid);

    // --------------------
    // candidates

    // a full buffer always goes before the writer's current item
    always_comb begin
        for (int wr = 0; wr < WR_COUNT; wr++) begin
            cand_valid[wr] = buf_valid[wr] | wb_valid[wr];
            cand_data[wr] = buf_valid[wr] ? buf_data[wr] : wb_data[wr];
            cand_pr[wr] = buf_valid[wr] ? buf_pr[wr] : wb_pr[wr];
        end

        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                req_by_bank[b][wr] = cand_valid[wr]
                    && (cand_pr[wr][LOG_BANK_COUNT-1:0] == LOG_BANK_COUNT'(b));
            end
        end
    end

    // one winner per bank
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        masked_priority_picker #(
            .WIDTH(WR_COUNT)
        ) u_bank_pick (
            .req  (req_by_bank[b]),
            .mask (last_mask),
            .grant(grant_by_bank[b])
        );
    end

    // --------------------
    // bus select and mask

    always_comb begin
        wb_ack = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            wb_ack |= grant_by_bank[b];
        end

        next_mask = '0;
        for (int wr = WR_COUNT - 2; wr >= 0; wr--) begin
            next_mask[wr] = wb_ack[wr+1] | next_mask[wr+1];
        end

        // AND-OR mux on the one-hot grant
        for (int b = 0; b < BANK_COUNT; b++) begin
            next_bus_valid[b] = |req_by_bank[b];
            next_bus_row[b] = '0;
            next_bus_data[b] = '0;
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                next_bus_row[b] |= cand_pr[wr][LOG_PR_COUNT-1:LOG_BANK_COUNT]
                    & {UPPER_PR_WIDTH{grant_by_bank[b][wr]}};
                next_bus_data[b] |= cand_data[wr] & {DATA_WIDTH{grant_by_bank[b][wr]}};
            end
        end
    end

    // --------------------
    // state

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            buf_valid <= '0;
            buf_data <= '0;
            buf_pr <= '0;
            last_mask <= '0;
            wb_bus_valid <= '0;
            wb_bus_row <= '0;
            wb_bus_data <= '0;
            forward_data <= '0;
        end else begin
            // losers stay or move into the buffer
            buf_valid <= cand_valid & ~wb_ack;
            for (int wr = 0; wr < WR_COUNT; wr++) begin
                if (!buf_valid[wr]) begin
                    buf_data[wr] <= wb_data[wr];
                    buf_pr[wr] <= wb_pr[wr];
                end
            end
            last_mask <= next_mask;
            wb_bus_valid <= next_bus_valid;
            wb_bus_row <= next_bus_row;
            wb_bus_data <= next_bus_data;
            forward_data <= wb_bus_data;
        end
    end

    // a stalled writer keeps its item steady until it is taken
    for (genvar wr = 0; wr < WR_COUNT; wr++) begin : g_stall_check
        stalled_writer_holds: assert property (
            @(posedge CLK) disable iff (!nRST)
            (wb_valid[wr] && !wb_ready[wr])
                |=> (wb_valid[wr] && $stable(wb_data[wr]) && $stable(wb_pr[wr]))
        ) else $error("writer %0d changed its item while stalled", wr);
    end

endmodule
